//--- project.f
+incdir+include
hdl/axis_pkg.sv
hdl/axis_stream_master.sv
hdl/axis_stream_fifo.sv
hdl/axis_stream_slave.sv
hdl/axis_loopback.sv
test/tb_axis_loopback.sv

//--- Makefile
TOP := tb_axis_loopback
OBJ := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f project.f
	verilator --lint-only --top-module axis_loopback \
		hdl/axis_pkg.sv hdl/axis_stream_master.sv hdl/axis_stream_fifo.sv \
		hdl/axis_stream_slave.sv hdl/axis_loopback.sv

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f project.f \
		-Mdir $(OBJ) -o sim_$(TOP)
	@out="$$(./$(OBJ)/sim_$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'Regression passed'

clean:
	rm -rf $(OBJ)

//--- include/tb_steps.svh
`ifndef TB_STEPS_SVH
`define TB_STEPS_SVH

typedef enum logic [1:0] {
	STEP_WRITE,
	STEP_READ,
	STEP_IDLE
} step_kind_t;

typedef struct packed {
	step_kind_t kind;
	word_t data;
	logic rand_data; // take data from $urandom instead
	logic [7:0] count; // cycles, STEP_IDLE only
} step_t;

localparam step_t RD = '{STEP_READ, '0, 1'b0, 8'd0};
localparam step_t GAP = '{STEP_IDLE, '0, 1'b0, 8'd1}; // lets a write settle
localparam step_t WR_RND = '{STEP_WRITE, '0, 1'b1, 8'd0};

function automatic step_t wr(input word_t d);
	return '{STEP_WRITE, d, 1'b0, 8'd0};
endfunction

function automatic step_t idle(input int n);
	return '{STEP_IDLE, '0, 1'b0, 8'(n)};
endfunction

localparam int NUM_STEPS = 113;

localparam step_t STEPS [NUM_STEPS] = '{
	// two frames of known words, then read back
	wr(32'h0000_0101), GAP, wr(32'h0000_0102), GAP, wr(32'h0000_0103), GAP,
	wr(32'h0000_0104), GAP, wr(32'h0000_0105), GAP, wr(32'h0000_0106), GAP,
	wr(32'h0000_0107), GAP, wr(32'h0000_0108), GAP, idle(2),
	RD, RD, RD, RD, RD, RD, RD, RD,
	RD, RD, // nothing held
	// 20 writes into 18 places, last two dropped
	WR_RND, GAP, WR_RND, GAP, WR_RND, GAP, WR_RND, GAP, WR_RND, GAP,
	WR_RND, GAP, WR_RND, GAP, WR_RND, GAP, WR_RND, GAP, WR_RND, GAP,
	WR_RND, GAP, WR_RND, GAP, WR_RND, GAP, WR_RND, GAP, WR_RND, GAP,
	WR_RND, GAP, WR_RND, GAP, WR_RND, GAP, WR_RND, GAP, WR_RND, GAP,
	idle(2),
	RD, RD, RD, RD, RD, RD, RD, RD, RD,
	RD, RD, RD, RD, RD, RD, RD, RD, RD,
	RD, // drained
	// mixed traffic around an empty pipeline
	wr(32'h0000_0201), GAP, wr(32'h0000_0202), GAP, idle(2), RD,
	wr(32'h0000_0203), GAP, RD, idle(2), RD, RD,
	wr(32'h0000_0204), GAP, wr(32'h0000_0205), GAP, wr(32'h0000_0206), GAP,
	wr(32'h0000_0207), GAP, idle(2), RD, RD, RD, RD, idle(4)
};

`endif

//--- test/tb_axis_loopback.sv
`timescale 1ns/1ns

module tb_axis_loopback
	import axis_pkg::*;
();

	localparam int CLK_PERIOD = 4;
	localparam int DRIVE_DELAY = 1; // inputs change this long after the rising edge
	localparam int RESET_CYCLES = 3;
	localparam int SEED = 64;
	localparam int WATCHDOG_MARGIN = 100;

	// one word in the master, the fifo, one word in the slave
	localparam int CAPACITY = FIFO_DEPTH + 2;

	`include "tb_steps.svh"

	logic  m00_axis_aclk;
	logic  reset;
	logic  wen;
	word_t wdata;
	logic  ren;
	word_t rdata;
	logic  rvalid;
	logic  r_ready;
	logic  error_full;
	logic  error_empty;
	logic  error_frame;

	word_t model_q [$]; // words stored in the pipeline, oldest first

	int check_count;
	int error_count;
	int words_written;
	int words_dropped;
	int words_read;

	axis_loopback u_dut (
		.m00_axis_aclk(m00_axis_aclk),
		.reset(reset),
		.wen(wen),
		.wdata(wdata),
		.ren(ren),
		.rdata(rdata),
		.rvalid(rvalid),
		.r_ready(r_ready),
		.error_full(error_full),
		.error_empty(error_empty),
		.error_frame(error_frame)
	);

	initial begin
		m00_axis_aclk = 1'b0;
		forever #(CLK_PERIOD / 2) m00_axis_aclk = ~m00_axis_aclk;
	end

	function automatic int step_cycles(input step_t s);
		if (s.kind == STEP_IDLE)
			return int'(s.count);
		return 1;
	endfunction

	// limit follows the table, plus reset and some slack
	initial begin : watchdog
		int limit_cycles;
		limit_cycles = RESET_CYCLES + WATCHDOG_MARGIN;
		for (int i = 0; i < NUM_STEPS; i++)
			limit_cycles += step_cycles(STEPS[i]);
		#(limit_cycles * CLK_PERIOD);
		$display("timeout: the step table did not finish within %0d cycles", limit_cycles);
		$display("Regression failed");
		$finish;
	end

	task automatic check_value(input string name, input word_t got, input word_t expected);
		check_count++;
		if (got !== expected) begin
			error_count++;
			$display("CHECK FAILED %s: got 0x%08h, expected 0x%08h at %0t ns",
				name, got, expected, $time);
		end
	endtask

	// one rising edge, then settle to the drive point
	task automatic step_clock();
		@(posedge m00_axis_aclk);
		#DRIVE_DELAY;
	endtask

	// outputs registered on the edge just passed
	task automatic check_cycle(input logic exp_rvalid, input word_t exp_rdata,
			input logic exp_empty, input logic exp_full);
		check_value("rvalid", word_t'(rvalid), word_t'(exp_rvalid));
		if (exp_rvalid)
			check_value("rdata", rdata, exp_rdata);
		check_value("error_empty", word_t'(error_empty), word_t'(exp_empty));
		check_value("error_full", word_t'(error_full), word_t'(exp_full));
		check_value("error_frame", word_t'(error_frame), '0); // whole frames only
	endtask

	task automatic check_reset_state();
		check_value("r_ready", word_t'(r_ready), '0);
		check_value("rvalid", word_t'(rvalid), '0);
		check_value("error_full", word_t'(error_full), '0);
		check_value("error_empty", word_t'(error_empty), '0);
		check_value("error_frame", word_t'(error_frame), '0);
	endtask

	task automatic apply_write(input word_t d);
		logic room;
		room = (model_q.size() < CAPACITY);
		wen = 1'b1;
		wdata = d;
		step_clock();
		wen = 1'b0;
		wdata = '0;
		if (room) begin
			model_q.push_back(d);
			words_written++;
		end else begin
			words_dropped++; // no room anywhere, word is lost
		end
		check_cycle(1'b0, '0, 1'b0, ~room);
	endtask

	task automatic apply_read();
		logic have;
		word_t exp_word;
		have = (model_q.size() != 0);
		exp_word = '0;
		// r_ready must agree with the model before ren goes out
		check_value("r_ready", word_t'(r_ready), word_t'(have));
		if (have)
			exp_word = model_q.pop_front();
		ren = 1'b1;
		step_clock();
		ren = 1'b0;
		check_cycle(have, exp_word, ~have, 1'b0);
		if (have)
			words_read++;
	endtask

	task automatic apply_idle(input int n);
		repeat (n) begin
			step_clock();
			check_cycle(1'b0, '0, 1'b0, 1'b0);
		end
	endtask

	task automatic check_drained();
		check_value("r_ready", word_t'(r_ready), '0);
	endtask

	initial begin : main
		step_t s;
		word_t d;

		reset = 1'b1;
		wen = 1'b0;
		wdata = '0;
		ren = 1'b0;
		check_count = 0;
		error_count = 0;
		words_written = 0;
		words_dropped = 0;
		words_read = 0;
		void'($urandom(SEED));

		repeat (RESET_CYCLES) @(posedge m00_axis_aclk);
		#DRIVE_DELAY;
		reset = 1'b0;
		check_reset_state();

		for (int i = 0; i < NUM_STEPS; i++) begin
			s = STEPS[i];
			case (s.kind)
				STEP_WRITE: begin
					d = s.rand_data ? word_t'($urandom()) : s.data;
					apply_write(d);
				end
				STEP_READ: apply_read();
				default: apply_idle(int'(s.count));
			endcase
		end

		check_drained();

		$display("checks %0d, errors %0d, written %0d, dropped %0d, read %0d, frames %0d",
			check_count, error_count, words_written, words_dropped, words_read,
			words_read / FRAME_WORDS);
		if (error_count == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

//--- hdl/axis_loopback.sv
`timescale 1ns/1ns

module axis_loopback
	import axis_pkg::*;
(
	input  logic  m00_axis_aclk,
	input  logic  reset,

	input  logic  wen,
	input  word_t wdata,

	input  logic  ren,
	output word_t rdata,
	output logic  rvalid,
	output logic  r_ready,

	output logic  error_full,
	output logic  error_empty,
	output logic  error_frame
);

	// master to fifo
	logic  m_tvalid;
	word_t m_tdata;
	logic  m_tlast;
	logic  m_tready;

	// fifo to slave
	logic  s_tvalid;
	word_t s_tdata;
	logic  s_tlast;
	logic  s_tready;

	axis_stream_master u_master (
		.m00_axis_aclk(m00_axis_aclk),
		.reset(reset),
		.wen(wen),
		.wdata(wdata),
		.m_tvalid(m_tvalid),
		.m_tdata(m_tdata),
		.m_tlast(m_tlast),
		.m_tready(m_tready),
		.error_full(error_full)
	);

	axis_stream_fifo u_fifo (
		.m00_axis_aclk(m00_axis_aclk),
		.reset(reset),
		.in_tvalid(m_tvalid),
		.in_tdata(m_tdata),
		.in_tlast(m_tlast),
		.in_tready(m_tready),
		.out_tvalid(s_tvalid),
		.out_tdata(s_tdata),
		.out_tlast(s_tlast),
		.out_tready(s_tready)
	);

	axis_stream_slave u_slave (
		.m00_axis_aclk(m00_axis_aclk),
		.reset(reset),
		.s_tvalid(s_tvalid),
		.s_tdata(s_tdata),
		.s_tlast(s_tlast),
		.s_tready(s_tready),
		.ren(ren),
		.rdata(rdata),
		.rvalid(rvalid),
		.r_ready(r_ready),
		.error_empty(error_empty),
		.error_frame(error_frame)
	);

endmodule

//--- hdl/axis_stream_slave.sv
`timescale 1ns/1ns

module axis_stream_slave
	import axis_pkg::*;
(
	input  logic  m00_axis_aclk,
	input  logic  reset,

	input  logic  s_tvalid,
	input  word_t s_tdata,
	input  logic  s_tlast,
	output logic  s_tready,

	input  logic  ren,
	output word_t rdata,
	output logic  rvalid,
	output logic  r_ready,

	output logic  error_empty,
	output logic  error_frame
);

	word_t held_data;
	logic held;
	frame_count_t recv_count;
	logic take;
	logic serve;
	logic expect_last;

	// the held word may be replaced on the edge that reads it
	assign s_tready = ~held | ren;
	assign r_ready = held;

	assign take = s_tvalid & s_tready;
	assign serve = ren & held;
	assign expect_last = (recv_count == LAST_IDX);

	always_ff @(posedge m00_axis_aclk) begin
		if (reset) begin
			held <= 1'b0;
			recv_count <= '0;
			rvalid <= 1'b0;
			error_empty <= 1'b0;
			error_frame <= 1'b0;
		end else begin
			rvalid <= serve;
			error_empty <= ren & ~held;
			error_frame <= take & (s_tlast != expect_last);

			if (take)
				held <= 1'b1;
			else if (serve)
				held <= 1'b0;

			if (take)
				recv_count <= expect_last ? '0 : recv_count + 1'b1; // own count, not tlast
		end
	end

	always_ff @(posedge m00_axis_aclk) begin
		if (take)
			held_data <= s_tdata;
		if (serve)
			rdata <= held_data; // old word, take above lands on the same edge
	end

	a_read_excl: assert property (@(posedge m00_axis_aclk) disable iff (reset)
		!(rvalid && error_empty));

endmodule

//--- hdl/axis_stream_fifo.sv
`timescale 1ns/1ns

module axis_stream_fifo
	import axis_pkg::*;
(
	input  logic  m00_axis_aclk,
	input  logic  reset,

	input  logic  in_tvalid,
	input  word_t in_tdata,
	input  logic  in_tlast,
	output logic  in_tready,

	output logic  out_tvalid,
	output word_t out_tdata,
	output logic  out_tlast,
	input  logic  out_tready
);

	word_t mem_data [FIFO_DEPTH];
	logic  mem_last [FIFO_DEPTH];

	fifo_ptr_t wr_ptr;
	fifo_ptr_t rd_ptr;
	fifo_count_t count;
	logic push;
	logic pop;

	function automatic fifo_ptr_t ptr_inc(input fifo_ptr_t p);
		return (p == PTR_LAST) ? '0 : p + 1'b1;
	endfunction

	assign in_tready = (count < FIFO_FULL);
	assign out_tvalid = (count != '0);
	assign push = in_tvalid & in_tready;
	assign pop = out_tvalid & out_tready;

	// head entry is read straight from the array
	assign out_tdata = mem_data[rd_ptr];
	assign out_tlast = mem_last[rd_ptr];

	always_ff @(posedge m00_axis_aclk) begin
		if (push) begin
			mem_data[wr_ptr] <= in_tdata;
			mem_last[wr_ptr] <= in_tlast;
		end
	end

	always_ff @(posedge m00_axis_aclk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop)
				rd_ptr <= ptr_inc(rd_ptr);

			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // idle, or one in and one out
			endcase
		end
	end

	a_count_range: assert property (@(posedge m00_axis_aclk) disable iff (reset)
		count <= FIFO_FULL);

	// at full the pointers meet and nothing may be pushed over the head
	a_no_write_full: assert property (@(posedge m00_axis_aclk) disable iff (reset)
		count == FIFO_FULL |-> wr_ptr == rd_ptr && !push);

endmodule

//--- hdl/axis_stream_master.sv
`timescale 1ns/1ns

module axis_stream_master
	import axis_pkg::*;
(
	input  logic  m00_axis_aclk,
	input  logic  reset,

	input  logic  wen,
	input  word_t wdata,

	output logic  m_tvalid,
	output word_t m_tdata,
	output logic  m_tlast,
	input  logic  m_tready,

	output logic  error_full
);

	frame_count_t sent_count; // words already sent in the current frame
	logic xfer;
	logic accept;

	assign xfer = m_tvalid & m_tready;

	// room if empty, or the held word leaves on this edge
	assign accept = wen & (~m_tvalid | m_tready);

	// sent_count only moves on a transfer, so tlast stays put while waiting
	assign m_tlast = (sent_count == LAST_IDX);

	always_ff @(posedge m00_axis_aclk) begin
		if (reset) begin
			m_tvalid <= 1'b0;
			sent_count <= '0;
			error_full <= 1'b0;
		end else begin
			error_full <= wen & ~accept; // word dropped
			if (accept)
				m_tvalid <= 1'b1;
			else if (xfer)
				m_tvalid <= 1'b0;

			if (xfer)
				sent_count <= m_tlast ? '0 : sent_count + 1'b1;
		end
	end

	always_ff @(posedge m00_axis_aclk) begin
		if (accept)
			m_tdata <= wdata;
	end

	// a stalled beat must not change under the receiver
	a_stall_stable: assert property (@(posedge m00_axis_aclk) disable iff (reset)
		m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata) && $stable(m_tlast));

endmodule

//--- hdl/axis_pkg.sv
package axis_pkg;

	localparam int DATA_WIDTH = 32;
	localparam int FRAME_WORDS = 4; // tlast on the last of these
	localparam int FIFO_DEPTH = 16;

	localparam int PTR_WIDTH = $clog2(FIFO_DEPTH);
	localparam int FRAME_CNT_WIDTH = $clog2(FRAME_WORDS);

	typedef logic [DATA_WIDTH-1:0] word_t;
	typedef logic [PTR_WIDTH-1:0] fifo_ptr_t;
	typedef logic [PTR_WIDTH:0] fifo_count_t; // 0 .. FIFO_DEPTH
	typedef logic [FRAME_CNT_WIDTH-1:0] frame_count_t;

	// index of the word that carries tlast
	localparam frame_count_t LAST_IDX = frame_count_t'(FRAME_WORDS - 1);

	localparam fifo_count_t FIFO_FULL = fifo_count_t'(FIFO_DEPTH);
	localparam fifo_ptr_t PTR_LAST = fifo_ptr_t'(FIFO_DEPTH - 1);

endpackage
